/* design/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath word and register numbering
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define NUM_REGS        32

// rising edges from pair capture to write-back outputs
`define WB_LATENCY      3

`endif

/* design/isaPkg.sv */
`include "core_params.svh"

package isaPkg;

    // primary opcodes, anything else decodes as a no-op
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        ADDI  = 6'h08,
        ORI   = 6'h0d
    } opcodeE;

    // R-type function codes
    typedef enum logic [5:0] {
        SLL = 6'h00,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5
    } aluOpE;

    // immediate is the low 16 bits, i.e. {rd, shamt, funct}
    typedef struct packed {
        opcodeE                      opcode;
        logic [`REG_ADDR_WIDTH-1:0]  rs;
        logic [`REG_ADDR_WIDTH-1:0]  rt;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`REG_ADDR_WIDTH-1:0]  shamt;
        functE                       funct;
    } instrS;

endpackage

/* design/pipePkg.sv */
`include "core_params.svh"

package pipePkg;

    // per-lane control from the decoder
    typedef struct packed {
        logic           regWrite;
        logic           aluSrc;
        logic           immSigned;
        isaPkg::aluOpE  aluOp;
    } laneCtrlS;

    // one lane of the decode/execute register
    typedef struct packed {
        laneCtrlS                    ctrl;
        logic [`REG_ADDR_WIDTH-1:0]  rs;
        logic [`REG_ADDR_WIDTH-1:0]  rt;
        // zero when the lane writes nothing
        logic [`REG_ADDR_WIDTH-1:0]  dest;
        logic [`REG_ADDR_WIDTH-1:0]  shamt;
        logic [`DATA_WIDTH-1:0]      rsData;
        logic [`DATA_WIDTH-1:0]      rtData;
        // already extended
        logic [`DATA_WIDTH-1:0]      imm;
    } exLaneS;

endpackage

/* design/wbBusIf.sv */
`timescale 1ns/1ps

interface wbBusIf #(
    parameter int DataWidth = 32,
    parameter int AddrWidth = 5
);
    // lane 1 result
    logic                 en1;
    logic [AddrWidth-1:0] reg1;
    logic [DataWidth-1:0] data1;
    // lane 2 result, wins on a same-register collision
    logic                 en2;
    logic [AddrWidth-1:0] reg2;
    logic [DataWidth-1:0] data2;

    modport source (output en1, reg1, data1, en2, reg2, data2);
    modport sink   (input  en1, reg1, data1, en2, reg2, data2);
endinterface

/* design/controlUnit.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module controlUnit (
    input  isaPkg::instrS     instr,
    output pipePkg::laneCtrlS ctrl
);

    always_comb begin
        // default is a no-op lane
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSigned = 1'b0;
        ctrl.aluOp     = isaPkg::ALU_ADD;
        case (instr.opcode)
            isaPkg::RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (instr.funct)
                    isaPkg::ADD: ctrl.aluOp = isaPkg::ALU_ADD;
                    isaPkg::SUB: ctrl.aluOp = isaPkg::ALU_SUB;
                    isaPkg::AND: ctrl.aluOp = isaPkg::ALU_AND;
                    isaPkg::OR:  ctrl.aluOp = isaPkg::ALU_OR;
                    isaPkg::SLT: ctrl.aluOp = isaPkg::ALU_SLT;
                    isaPkg::SLL: ctrl.aluOp = isaPkg::ALU_SLL;
                    // unknown funct writes nothing
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            isaPkg::ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSigned = 1'b1;
            end
            isaPkg::ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = isaPkg::ALU_OR;
            end
            default: ;
        endcase
    end

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module registerFile (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddr2,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddr3,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddr4,
    wbBusIf.sink                       wb,
    output logic [`DATA_WIDTH-1:0]     rdData1,
    output logic [`DATA_WIDTH-1:0]     rdData2,
    output logic [`DATA_WIDTH-1:0]     rdData3,
    output logic [`DATA_WIDTH-1:0]     rdData4
);

    logic [`DATA_WIDTH-1:0]     regs  [`NUM_REGS];
    logic [`REG_ADDR_WIDTH-1:0] addrs [4];
    logic [`DATA_WIDTH-1:0]     datas [4];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.en1 && wb.reg1 != '0) begin
                regs[wb.reg1] <= wb.data1;
            end
            // lane 2 is later in program order, its write lands last
            if (wb.en2 && wb.reg2 != '0) begin
                regs[wb.reg2] <= wb.data2;
            end
        end
    end

    assign addrs = '{rdAddr1, rdAddr2, rdAddr3, rdAddr4};

    // combinational reads with write-through, same lane priority as the write
    for (genvar p = 0; p < 4; p++) begin : gRead
        assign datas[p] = (addrs[p] == '0)                    ? '0 :
                          (wb.en2 && wb.reg2 == addrs[p])     ? wb.data2 :
                          (wb.en1 && wb.reg1 == addrs[p])     ? wb.data1 :
                                                                regs[addrs[p]];
    end

    assign rdData1 = datas[0];
    assign rdData2 = datas[1];
    assign rdData3 = datas[2];
    assign rdData4 = datas[3];

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0]     a,
    input  logic [`DATA_WIDTH-1:0]     b,
    input  logic [`REG_ADDR_WIDTH-1:0] shamt,
    input  isaPkg::aluOpE              op,
    output logic [`DATA_WIDTH-1:0]     y
);

    logic lessThan;

    // signed compare for SLT
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            isaPkg::ALU_ADD: y = a + b;
            isaPkg::ALU_SUB: y = a - b;
            isaPkg::ALU_AND: y = a & b;
            isaPkg::ALU_OR:  y = a | b;
            isaPkg::ALU_SLT: y = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            // shifts rt, rs is ignored
            isaPkg::ALU_SLL: y = b << shamt;
            default:         y = '0;
        endcase
    end

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module decodeStage (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       pairValid,
    input  logic [`DATA_WIDTH-1:0]     instr1,
    input  logic [`DATA_WIDTH-1:0]     instr2,
    input  logic [`DATA_WIDTH-1:0]     rdData1,
    input  logic [`DATA_WIDTH-1:0]     rdData2,
    input  logic [`DATA_WIDTH-1:0]     rdData3,
    input  logic [`DATA_WIDTH-1:0]     rdData4,
    output logic [`REG_ADDR_WIDTH-1:0] rdAddr1,
    output logic [`REG_ADDR_WIDTH-1:0] rdAddr2,
    output logic [`REG_ADDR_WIDTH-1:0] rdAddr3,
    output logic [`REG_ADDR_WIDTH-1:0] rdAddr4,
    output logic                       exValid,
    output pipePkg::exLaneS            exLane1,
    output pipePkg::exLaneS            exLane2
);

    logic              idValid;
    isaPkg::instrS     idInstr1;
    isaPkg::instrS     idInstr2;
    pipePkg::laneCtrlS ctrl1;
    pipePkg::laneCtrlS ctrl2;

    // assemble one lane record from its instruction, control and operands
    function automatic pipePkg::exLaneS buildLane(
        input isaPkg::instrS          ins,
        input pipePkg::laneCtrlS      ctrl,
        input logic [`DATA_WIDTH-1:0] rsData,
        input logic [`DATA_WIDTH-1:0] rtData
    );
        pipePkg::exLaneS lane;
        logic [15:0]     imm16;
        imm16       = ins[15:0];
        lane.ctrl   = ctrl;
        lane.rs     = ins.rs;
        lane.rt     = ins.rt;
        lane.shamt  = ins.shamt;
        lane.rsData = rsData;
        lane.rtData = rtData;
        if (!ctrl.regWrite) begin
            lane.dest = '0;
        end else if (ins.opcode == isaPkg::RTYPE) begin
            lane.dest = ins.rd;
        end else begin
            lane.dest = ins.rt;
        end
        lane.imm = ctrl.immSigned ? {{(`DATA_WIDTH-16){imm16[15]}}, imm16}
                                  : {{(`DATA_WIDTH-16){1'b0}}, imm16};
        return lane;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idValid <= 1'b0;
            exValid <= 1'b0;
        end else begin
            idValid <= pairValid;
            exValid <= idValid;
        end
    end

    controlUnit cu1 (.instr(idInstr1), .ctrl(ctrl1));
    controlUnit cu2 (.instr(idInstr2), .ctrl(ctrl2));

    assign rdAddr1 = idInstr1.rs;
    assign rdAddr2 = idInstr1.rt;
    assign rdAddr3 = idInstr2.rs;
    assign rdAddr4 = idInstr2.rt;

    // payload follows the valid bits
    always_ff @(posedge clk) begin
        idInstr1 <= isaPkg::instrS'(instr1);
        idInstr2 <= isaPkg::instrS'(instr2);
        exLane1  <= buildLane(idInstr1, ctrl1, rdData1, rdData2);
        exLane2  <= buildLane(idInstr2, ctrl2, rdData3, rdData4);
    end

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module executeStage (
    input  logic            clk,
    input  logic            arstN,
    input  logic            exValid,
    input  pipePkg::exLaneS exLane1,
    input  pipePkg::exLaneS exLane2,
    wbBusIf.source          wbOut,
    wbBusIf.sink            wbFwd
);

    pipePkg::exLaneS        lanes  [2];
    logic [`DATA_WIDTH-1:0] result [2];

    assign lanes[0] = exLane1;
    assign lanes[1] = exLane2;

    for (genvar l = 0; l < 2; l++) begin : gLane
        logic                   hitA1;
        logic                   hitA2;
        logic                   hitB1;
        logic                   hitB2;
        logic [`DATA_WIDTH-1:0] srcA;
        logic [`DATA_WIDTH-1:0] srcB;
        logic [`DATA_WIDTH-1:0] opB;

        // matches against the write-back register, r0 never forwards
        assign hitA1 = wbFwd.en1 && wbFwd.reg1 == lanes[l].rs && lanes[l].rs != '0;
        assign hitA2 = wbFwd.en2 && wbFwd.reg2 == lanes[l].rs && lanes[l].rs != '0;
        assign hitB1 = wbFwd.en1 && wbFwd.reg1 == lanes[l].rt && lanes[l].rt != '0;
        assign hitB2 = wbFwd.en2 && wbFwd.reg2 == lanes[l].rt && lanes[l].rt != '0;

        // lane 2 checked first so it overrides lane 1
        assign srcA = hitA2 ? wbFwd.data2 :
                      hitA1 ? wbFwd.data1 : lanes[l].rsData;
        assign srcB = hitB2 ? wbFwd.data2 :
                      hitB1 ? wbFwd.data1 : lanes[l].rtData;

        assign opB = lanes[l].ctrl.aluSrc ? lanes[l].imm : srcB;

        alu uAlu (
            .a     (srcA),
            .b     (opB),
            .shamt (lanes[l].shamt),
            .op    (lanes[l].ctrl.aluOp),
            .y     (result[l])
        );
    end

    // write-back register, enables act as its valid bits
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbOut.en1 <= 1'b0;
            wbOut.en2 <= 1'b0;
        end else begin
            wbOut.en1 <= exValid && exLane1.dest != '0;
            wbOut.en2 <= exValid && exLane2.dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        wbOut.reg1  <= exLane1.dest;
        wbOut.data1 <= result[0];
        wbOut.reg2  <= exLane2.dest;
        wbOut.data2 <= result[1];
    end

endmodule

/* design/dualIssueCore.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module dualIssueCore (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       pairValid,
    input  logic [`DATA_WIDTH-1:0]     instr1,
    input  logic [`DATA_WIDTH-1:0]     instr2,
    output logic                       wbEn1,
    output logic                       wbEn2,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg1,
    output logic [`REG_ADDR_WIDTH-1:0] wbReg2,
    output logic [`DATA_WIDTH-1:0]     wbData1,
    output logic [`DATA_WIDTH-1:0]     wbData2
);

    logic [`REG_ADDR_WIDTH-1:0] rdAddr1, rdAddr2, rdAddr3, rdAddr4;
    logic [`DATA_WIDTH-1:0]     rdData1, rdData2, rdData3, rdData4;
    logic                       exValid;
    pipePkg::exLaneS            exLane1;
    pipePkg::exLaneS            exLane2;

    wbBusIf #(.DataWidth(`DATA_WIDTH), .AddrWidth(`REG_ADDR_WIDTH)) wbBus ();

    decodeStage uDecode (
        .clk, .arstN, .pairValid, .instr1, .instr2,
        .rdData1, .rdData2, .rdData3, .rdData4,
        .rdAddr1, .rdAddr2, .rdAddr3, .rdAddr4,
        .exValid, .exLane1, .exLane2
    );

    registerFile uRegFile (
        .clk, .arstN,
        .rdAddr1, .rdAddr2, .rdAddr3, .rdAddr4,
        .wb (wbBus),
        .rdData1, .rdData2, .rdData3, .rdData4
    );

    // drives the bus and reads it back for forwarding
    executeStage uExecute (
        .clk, .arstN, .exValid, .exLane1, .exLane2,
        .wbOut (wbBus),
        .wbFwd (wbBus)
    );

    assign wbEn1   = wbBus.en1;
    assign wbReg1  = wbBus.reg1;
    assign wbData1 = wbBus.data1;
    assign wbEn2   = wbBus.en2;
    assign wbReg2  = wbBus.reg2;
    assign wbData2 = wbBus.data2;

endmodule

/* dv/coreSva.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module coreSva (
    input logic                       clk,
    input logic                       arstN,
    input logic                       pairValid,
    input logic                       wbEn1,
    input logic                       wbEn2,
    input logic [`REG_ADDR_WIDTH-1:0] wbReg1,
    input logic [`REG_ADDR_WIDTH-1:0] wbReg2
);

    // register 0 is never written back
    assert property (@(posedge clk) disable iff (!arstN) wbEn1 |-> wbReg1 != '0)
        else $error("lane 1 write-back enabled for register 0");
    assert property (@(posedge clk) disable iff (!arstN) wbEn2 |-> wbReg2 != '0)
        else $error("lane 2 write-back enabled for register 0");

    // a write-back needs a pair sampled three edges earlier, so reset and bubbles stay quiet
    assert property (@(posedge clk) disable iff (!arstN)
        wbEn1 |-> $past(pairValid, `WB_LATENCY))
        else $error("lane 1 write-back without a pair three edges earlier");
    assert property (@(posedge clk) disable iff (!arstN)
        wbEn2 |-> $past(pairValid, `WB_LATENCY))
        else $error("lane 2 write-back without a pair three edges earlier");

endmodule

bind dualIssueCore coreSva sva (
    .clk, .arstN, .pairValid, .wbEn1, .wbEn2, .wbReg1, .wbReg2
);

/* dv/tbDualIssue.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module clockGen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end
endmodule

module tbDualIssue;

    typedef struct packed {
        logic                       en;
        logic [`REG_ADDR_WIDTH-1:0] dst;
        logic [`DATA_WIDTH-1:0]     data;
    } laneS;

    typedef struct packed {
        laneS l1;
        laneS l2;
    } expS;

    logic                       clk;
    logic                       arstN;
    logic                       pairValid;
    logic [`DATA_WIDTH-1:0]     instr1;
    logic [`DATA_WIDTH-1:0]     instr2;
    logic                       wbEn1;
    logic                       wbEn2;
    logic [`REG_ADDR_WIDTH-1:0] wbReg1;
    logic [`REG_ADDR_WIDTH-1:0] wbReg2;
    logic [`DATA_WIDTH-1:0]     wbData1;
    logic [`DATA_WIDTH-1:0]     wbData2;

    logic [`DATA_WIDTH-1:0] model [`NUM_REGS];
    logic [31:0]            lfsr = 32'd73693;
    expS                    curExp;
    expS                    expPipe [`WB_LATENCY];
    expS                    expHead;
    string                  curTest = "reset";
    int                     errCount = 0;
    int                     testCount = 0;

    clockGen clkGen (.clk(clk));

    dualIssueCore uut (
        .clk, .arstN, .pairValid, .instr1, .instr2,
        .wbEn1, .wbEn2, .wbReg1, .wbReg2, .wbData1, .wbData2
    );

    // expected write-back travels the same number of edges as the pair
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `WB_LATENCY; i++) begin
                expPipe[i] <= '0;
            end
        end else begin
            expPipe[0] <= curExp;
            for (int i = 1; i < `WB_LATENCY; i++) begin
                expPipe[i] <= expPipe[i-1];
            end
        end
    end

    assign expHead = expPipe[`WB_LATENCY-1];

    task automatic reportValue(input string what, input logic [31:0] expv,
                               input logic [31:0] act);
        errCount++;
        $display("Fail %s %s: expected %h, actual %h", curTest, what, expv, act);
    endtask

    assert property (@(posedge clk) disable iff (!arstN) wbEn1 == expHead.l1.en)
        else reportValue("wbEn1", 32'($sampled(expHead.l1.en)), 32'($sampled(wbEn1)));
    assert property (@(posedge clk) disable iff (!arstN) wbEn2 == expHead.l2.en)
        else reportValue("wbEn2", 32'($sampled(expHead.l2.en)), 32'($sampled(wbEn2)));
    assert property (@(posedge clk) disable iff (!arstN)
        expHead.l1.en |-> wbReg1 == expHead.l1.dst)
        else reportValue("wbReg1", 32'($sampled(expHead.l1.dst)), 32'($sampled(wbReg1)));
    assert property (@(posedge clk) disable iff (!arstN)
        expHead.l1.en |-> wbData1 == expHead.l1.data)
        else reportValue("wbData1", $sampled(expHead.l1.data), $sampled(wbData1));
    assert property (@(posedge clk) disable iff (!arstN)
        expHead.l2.en |-> wbReg2 == expHead.l2.dst)
        else reportValue("wbReg2", 32'($sampled(expHead.l2.dst)), 32'($sampled(wbReg2)));
    assert property (@(posedge clk) disable iff (!arstN)
        expHead.l2.en |-> wbData2 == expHead.l2.data)
        else reportValue("wbData2", $sampled(expHead.l2.data), $sampled(wbData2));

    // Fibonacci LFSR on taps 32 22 2 1 stepping once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected result of one instruction against the model registers
    function automatic laneS execRef(input logic [31:0] ins);
        laneS        r;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        r   = '0;
        a   = model[ins[25:21]];
        b   = model[ins[20:16]];
        imm = ins[15:0];
        if (ins[31:26] == 6'h00) begin
            r.en  = 1'b1;
            r.dst = ins[15:11];
            case (ins[5:0])
                6'h20: r.data = a + b;
                6'h22: r.data = a - b;
                6'h24: r.data = a & b;
                6'h25: r.data = a | b;
                6'h2a: r.data = {31'b0, $signed(a) < $signed(b)};
                6'h00: r.data = b << ins[10:6];
                default: r.en = 1'b0;
            endcase
        end else if (ins[31:26] == 6'h08) begin
            r.en   = 1'b1;
            r.dst  = ins[20:16];
            r.data = a + {{16{imm[15]}}, imm};
        end else if (ins[31:26] == 6'h0d) begin
            r.en   = 1'b1;
            r.dst  = ins[20:16];
            r.data = a | {16'b0, imm};
        end
        if (r.dst == '0) begin
            r.en = 1'b0;
        end
        return r;
    endfunction

    function automatic logic [31:0] randInstr();
        logic [2:0]  k;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  funct;
        k   = 3'(randBits(3));
        rs  = 5'(randBits(5));
        rt  = 5'(randBits(5));
        rd  = 5'(randBits(5));
        sh  = 5'(randBits(5));
        imm = 16'(randBits(16));
        case (k)
            3'd0: funct = 6'h20;
            3'd1: funct = 6'h22;
            3'd2: funct = 6'h24;
            3'd3: funct = 6'h25;
            3'd4: funct = 6'h2a;
            default: funct = 6'h00;
        endcase
        if (k == 3'd6) begin
            return iType(6'h08, rs, rt, imm);
        end else if (k == 3'd7) begin
            return iType(6'h0d, rs, rt, imm);
        end
        return rType(funct, rs, rt, rd, sh);
    endfunction

    task automatic issue(input logic [31:0] i1, input logic [31:0] i2);
        expS e;
        @(posedge clk);
        e.l1 = execRef(i1);
        if (e.l1.en) begin
            model[e.l1.dst] = e.l1.data;
        end
        e.l2 = execRef(i2);
        if (e.l2.en) begin
            model[e.l2.dst] = e.l2.data;
        end
        pairValid <= 1'b1;
        instr1    <= i1;
        instr2    <= i2;
        curExp    <= e;
    endtask

    task automatic bubble();
        @(posedge clk);
        pairValid <= 1'b0;
        instr1    <= randBits(32);
        instr2    <= randBits(32);
        curExp    <= '0;
    endtask

    // instr2 must not read a register that instr1 writes
    task automatic issueRandom();
        logic [31:0] i1;
        logic [31:0] i2;
        laneS        l1;
        int          tries;
        i1    = randInstr();
        l1    = execRef(i1);
        tries = 0;
        do begin
            i2 = randInstr();
            tries++;
        end while (l1.en && (i2[25:21] == l1.dst || i2[20:16] == l1.dst) && tries < 100);
        if (tries >= 100) begin
            errCount++;
            $display("%s: no legal second instruction found", curTest);
        end
        issue(i1, i2);
    endtask

    task automatic finishTest(input int startErr);
        int waited;
        waited = 0;
        bubble();
        @(negedge clk);
        while ((wbEn1 || wbEn2 || curExp != '0 || expPipe[0] != '0 || expPipe[1] != '0 ||
                expPipe[2] != '0) && waited < 20) begin
            bubble();
            @(negedge clk);
            waited++;
        end
        if (waited >= 20) begin
            errCount++;
            $display("%s: pipeline did not drain in time", curTest);
        end
        testCount++;
        $display("%s done, %0d errors", curTest, errCount - startErr);
    endtask

    initial begin
        int startErr;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
        end
        arstN     = 1'b0;
        pairValid = 1'b0;
        instr1    = '0;
        instr2    = '0;
        curExp    = '0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        curTest  = "aluOps";
        startErr = errCount;
        for (int i = 0; i < 64; i++) begin
            issueRandom();
        end
        finishTest(startErr);

        curTest  = "forwarding";
        startErr = errCount;
        issue(iType(6'h0d, 5'd0, 5'd5, 16'h1234), iType(6'h08, 5'd0, 5'd6, 16'hff00));
        // cross-lane and same-lane reads of the pair just before
        issue(rType(6'h20, 5'd5, 5'd6, 5'd8, 5'd0), rType(6'h2a, 5'd6, 5'd5, 5'd9, 5'd0));
        issue(iType(6'h08, 5'd3, 5'd7, 16'h0011), iType(6'h0d, 5'd4, 5'd7, 16'h8001));
        issue(rType(6'h22, 5'd7, 5'd8, 5'd10, 5'd0), rType(6'h00, 5'd0, 5'd7, 5'd11, 5'd3));
        finishTest(startErr);

        curTest  = "writeThrough";
        startErr = errCount;
        issue(iType(6'h08, 5'd0, 5'd12, 16'h8765), iType(6'h0d, 5'd0, 5'd13, 16'h4321));
        issue(iType(6'h08, 5'd1, 5'd14, 16'h0001), iType(6'h08, 5'd2, 5'd15, 16'h0002));
        issue(rType(6'h25, 5'd12, 5'd13, 5'd16, 5'd0), rType(6'h24, 5'd13, 5'd12, 5'd17, 5'd0));
        issue(rType(6'h20, 5'd12, 5'd0, 5'd18, 5'd0), rType(6'h22, 5'd13, 5'd12, 5'd19, 5'd0));
        finishTest(startErr);

        curTest  = "reg0AndNoop";
        startErr = errCount;
        issue(iType(6'h08, 5'd5, 5'd0, 16'h7777), 32'hfc00_0000);
        issue(rType(6'h3f, 5'd5, 5'd6, 5'd20, 5'd0), rType(6'h20, 5'd5, 5'd6, 5'd0, 5'd0));
        issue(rType(6'h20, 5'd0, 5'd0, 5'd21, 5'd0), rType(6'h25, 5'd0, 5'd5, 5'd22, 5'd0));
        finishTest(startErr);

        curTest  = "bubbles";
        startErr = errCount;
        for (int i = 0; i < 48; i++) begin
            if (randBits(1)) begin
                bubble();
            end else begin
                issueRandom();
            end
        end
        finishTest(startErr);

        $display("%0d tests, %0d errors", testCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // hang guard for the whole run
    initial begin
        #200000;
        $display("run did not finish within its time limit");
        $display("Checks failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/wbBusIf.sv
design/controlUnit.sv
design/registerFile.sv
design/alu.sv
design/decodeStage.sv
design/executeStage.sv
design/dualIssueCore.sv
dv/coreSva.sv
dv/tbDualIssue.sv

/* run.sh */
#!/bin/sh
# build and run the dual-issue core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tbDualIssue -o simTb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/simTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "All checks passed"; then
    exit 0
fi
exit 1
